//--- logic/mem_params.svh
// Address and data widths of the memory subsystem.
// Included by the package and by every RTL file that sizes a port or an array.
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// word port: 32K words of 32 bits
`define MEM_WORD_AW 15
`define MEM_WORD_W  32

// byte port: the same storage seen as 128K bytes
`define MEM_BYTE_AW 17

// one single-port bank holds 16K halfwords
`define MEM_BANK_AW 14

`endif

//--- logic/forth_mem_pkg.sv
// Request types shared by the memory controller, the datapath blocks and
// the testbench. Widths come from the params header.
`include "mem_params.svh"

package forth_mem_pkg;

    // word access as issued by the CPU, or built by the byte port
    typedef struct packed {
        logic                    en;    // access strobe
        logic                    we;    // write
        logic [3:0]              bmsk;  // bit i enables byte i
        logic [`MEM_WORD_AW-1:0] ai;    // word address
        logic [`MEM_WORD_W-1:0]  vi;    // write data
    } word_req_t;

    // byte address, either flat or split into word and lane
    typedef union packed {
        logic [`MEM_BYTE_AW-1:0] raw;
        struct packed {
            logic [`MEM_WORD_AW-1:0] word;
            logic [1:0]              lane;  // little-endian byte index
        } fld;
    } byte_addr_u;

    // byte access from the debugger
    typedef struct packed {
        logic       en;
        logic       we;
        byte_addr_u ai;
        logic [7:0] vi;
    } byte_req_t;

endpackage

//--- logic/spram_bank.sv
// Behavioural model of a 16K x 16 single-port RAM bank.
// Nibble write mask and chip select as on the FPGA primitive; one cycle
// read latency, output held while the bank is not read.
`timescale 1ns/100ps
`include "mem_params.svh"

module spram_bank (
    input  logic                    clk,
    input  logic [`MEM_BANK_AW-1:0] ad,
    input  logic [15:0]             di,
    input  logic [3:0]              maskwe,  // one bit per nibble
    input  logic                    we,
    input  logic                    cs,
    output logic [15:0]             dout
);

    localparam int DEPTH = 1 << `MEM_BANK_AW;

    logic [15:0] mem [DEPTH];

    // write path, only the enabled nibbles change
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int i = 0; i < 4; i++) begin
                if (maskwe[i]) begin
                    mem[ad][i*4 +: 4] <= di[i*4 +: 4];
                end
            end
        end
    end

    // read path, dout keeps its value on writes and idle cycles
    always_ff @(posedge clk) begin
        if (cs && !we) begin
            dout <= mem[ad];
        end
    end

endmodule

//--- logic/word_mem.sv
// 32K x 32 word memory from four 16K x 16 banks.
// Address bit 14 picks the bank pair; each pair holds the low and high
// halfword of a word. Read data is valid one cycle after the request.
`timescale 1ns/100ps
`include "mem_params.svh"

module word_mem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  forth_mem_pkg::word_req_t      req,
    output logic [`MEM_WORD_W-1:0]        rd
);

    logic        half;       // pair addressed by the current request
    logic        half_q;     // pair of the last accepted read
    logic        rd_acc;
    logic [15:0] bank_do [4];  // index is {pair, halfword}

    assign half   = req.ai[`MEM_WORD_AW-1];
    assign rd_acc = req.en && !req.we;

    // one bank per halfword of each pair
    for (genvar b = 0; b < 4; b++) begin : g_bank
        localparam bit PAIR = b[1];
        localparam bit HI   = b[0];

        logic [3:0]  nib_we;
        logic [15:0] bank_di;

        // every byte mask bit covers two nibbles
        assign nib_we  = HI ? {{2{req.bmsk[3]}}, {2{req.bmsk[2]}}}
                            : {{2{req.bmsk[1]}}, {2{req.bmsk[0]}}};
        assign bank_di = HI ? req.vi[31:16] : req.vi[15:0];

        spram_bank spram_bank_inst (
            .clk    (clk),
            .ad     (req.ai[`MEM_BANK_AW-1:0]),
            .di     (bank_di),
            .maskwe (nib_we),
            .we     (req.we),
            .cs     (req.en && (half == PAIR)),
            .dout   (bank_do[b])
        );
    end

    // remember which pair was read, not which one is addressed now
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_q <= 1'b0;
        end else if (rd_acc) begin
            half_q <= half;
        end
    end

    assign rd = half_q ? {bank_do[3], bank_do[2]} : {bank_do[1], bank_do[0]};

    // a write with an empty mask would be silently lost
    a_write_mask: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req.en && req.we) |-> (req.bmsk != 4'b0000)
    );

endmodule

//--- logic/byte_port.sv
// Byte access to the word memory for the debugger.
// A byte write becomes a word write with a one-hot byte mask; a byte read
// fetches the whole word and picks the lane registered with the request.
`timescale 1ns/100ps
`include "mem_params.svh"

module byte_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  forth_mem_pkg::byte_req_t      req,
    input  logic [`MEM_WORD_W-1:0]        mem_rd,
    input  logic                          rd_take,  // byte read accepted
    output forth_mem_pkg::word_req_t      word_req,
    output logic [7:0]                    rd
);

    logic [1:0] lane;
    logic [1:0] lane_q;  // lane of the last accepted read

    assign lane = req.ai.fld.lane;

    // write byte on every lane and a one-hot mask for the target
    assign word_req.en   = req.en;
    assign word_req.we   = req.we;
    assign word_req.bmsk = 4'b0001 << lane;
    assign word_req.ai   = req.ai.fld.word;
    assign word_req.vi   = {4{req.vi}};

    // lane is only taken when the read is really served
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_q <= 2'd0;
        end else if (rd_take) begin
            lane_q <= lane;
        end
    end

    // lane 0 is bits 7:0 (little-endian)
    assign rd = mem_rd[{lane_q, 3'b000} +: 8];

    // a taken read must be a byte read issued by this port
    a_take_is_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_take |-> (req.en && !req.we)
    );

endmodule

//--- logic/mem_ctrl.sv
// Port selection for the shared word memory.
// dbg_mode picks the owner; the other port's requests are dropped.
// Each port sees its own last read word, with no added latency.
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dbg_mode,
    input  forth_mem_pkg::word_req_t      cpu_req,
    input  forth_mem_pkg::word_req_t      dbg_req,
    input  logic [`MEM_WORD_W-1:0]        mem_rd,
    output forth_mem_pkg::word_req_t      mem_req,
    output logic                          dbg_take,
    output logic [`MEM_WORD_W-1:0]        word_rd,
    output logic [`MEM_WORD_W-1:0]        dbg_rd
);

    import forth_mem_pkg::*;

    word_req_t              sel_req;
    logic                   rd_acc;     // read accepted this cycle
    logic                   rd_owner;   // 1 when the debugger read last
    logic [`MEM_WORD_W-1:0] word_hold;
    logic [`MEM_WORD_W-1:0] dbg_hold;

    assign sel_req = dbg_mode ? dbg_req : cpu_req;

    // nothing reaches the banks while in reset
    always_comb begin
        mem_req    = sel_req;
        mem_req.en = sel_req.en && rst_n;
    end

    assign rd_acc   = mem_req.en && !mem_req.we;
    assign dbg_take = rd_acc && dbg_mode;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_owner <= 1'b0;
        end else if (rd_acc) begin
            rd_owner <= dbg_mode;
        end
    end

    // freeze both views before the memory output moves on
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            word_hold <= word_rd;
            dbg_hold  <= dbg_rd;
        end
    end

    // the owner of the last read sees the live memory output
    assign word_rd = rd_owner ? word_hold : mem_rd;
    assign dbg_rd  = rd_owner ? mem_rd : dbg_hold;

    // a read of one port leaves the other port's output alone
    a_word_rd_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_acc && dbg_mode) |=> $stable(word_rd)
    );

    a_dbg_rd_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_acc && !dbg_mode) |=> $stable(dbg_rd)
    );

endmodule

//--- logic/forth_mem_top.sv
// Memory subsystem of the stack machine.
// Word port for the CPU, byte port for the debugger, dbg_mode selects
// which one owns the shared 32K x 32 memory.
`timescale 1ns/100ps
`include "mem_params.svh"

module forth_mem_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dbg_mode,
    input  forth_mem_pkg::word_req_t      word_req,
    input  forth_mem_pkg::byte_req_t      byte_req,
    output logic [`MEM_WORD_W-1:0]        word_rd,
    output logic [7:0]                    byte_rd
);

    import forth_mem_pkg::*;

    word_req_t              byte_word_req;  // byte request seen as a word access
    word_req_t              mem_req;
    logic [`MEM_WORD_W-1:0] mem_rd;
    logic [`MEM_WORD_W-1:0] dbg_rd;
    logic                   dbg_take;

    byte_port byte_port_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (byte_req),
        .mem_rd   (dbg_rd),
        .rd_take  (dbg_take),
        .word_req (byte_word_req),
        .rd       (byte_rd)
    );

    mem_ctrl mem_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .dbg_mode (dbg_mode),
        .cpu_req  (word_req),
        .dbg_req  (byte_word_req),
        .mem_rd   (mem_rd),
        .mem_req  (mem_req),
        .dbg_take (dbg_take),
        .word_rd  (word_rd),
        .dbg_rd   (dbg_rd)
    );

    word_mem word_mem_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rd    (mem_rd)
    );

endmodule

//--- sim/forth_mem_tasks.svh
// Driver, compare and test tasks for the memory subsystem testbench.
// Included inside the testbench module, works on its signals and model.
`ifndef FORTH_MEM_TASKS_SVH
`define FORTH_MEM_TASKS_SVH

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// only the enabled bytes of the stored word change
function automatic void model_write(input logic [`MEM_WORD_AW-1:0] addr,
                                    input logic [3:0] mask,
                                    input logic [`MEM_WORD_W-1:0] data);
    logic [`MEM_WORD_W-1:0] w;
    w = model.exists(addr) ? model[addr] : 'x;
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
            w[i*8 +: 8] = data[i*8 +: 8];
        end
    end
    model[addr] = w;
endfunction

task automatic check_word(input string what, input logic [`MEM_WORD_W-1:0] exp,
                          input logic [`MEM_WORD_W-1:0] act);
    if (act !== exp) begin
        abort_run($sformatf("error %s (%s): expected 0x%08h, actual 0x%08h",
                            cur_test, what, exp, act));
    end
endtask

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        abort_run($sformatf("error %s (%s): expected 0x%02h, actual 0x%02h",
                            cur_test, what, exp, act));
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
endtask

task automatic idle_ports();
    word_req = '0;
    byte_req = '0;
endtask

task automatic word_write(input logic [`MEM_WORD_AW-1:0] addr, input logic [3:0] mask,
                          input logic [`MEM_WORD_W-1:0] data);
    word_req      = '0;
    word_req.en   = 1'b1;
    word_req.we   = 1'b1;
    word_req.bmsk = mask;
    word_req.ai   = addr;
    word_req.vi   = data;
    if (!dbg_mode) begin
        model_write(addr, mask, data);  // dropped while the debugger owns memory
    end
    next_cycle();
    idle_ports();
endtask

task automatic word_read(input string what, input logic [`MEM_WORD_AW-1:0] addr);
    logic [`MEM_WORD_W-1:0] exp;
    logic                   served;
    served      = !dbg_mode;
    word_req    = '0;
    word_req.en = 1'b1;
    word_req.ai = addr;
    if (served && !model.exists(addr)) begin
        abort_run("test sequence reads a word it never wrote");
    end
    exp = served ? model[addr] : last_word;  // a dropped read keeps the old value
    next_cycle();
    idle_ports();
    if (served || word_seen) begin
        check_word(what, exp, word_rd);
    end
    if (byte_seen) begin
        check_byte({what, ", byte port held"}, last_byte, byte_rd);
    end
    if (served) begin
        last_word = exp;
        word_seen = 1'b1;
    end
endtask

task automatic byte_write(input logic [`MEM_WORD_AW-1:0] word, input logic [1:0] lane,
                          input logic [7:0] data);
    byte_addr_u             ba;
    logic [`MEM_WORD_W-1:0] w;
    ba.fld.word = word;
    ba.fld.lane = lane;
    byte_req    = '0;
    byte_req.en = 1'b1;
    byte_req.we = 1'b1;
    byte_req.ai = ba;
    byte_req.vi = data;
    if (dbg_mode) begin
        w = model.exists(word) ? model[word] : 'x;
        w[lane*8 +: 8] = data;  // lane 0 is the low byte
        model[word] = w;
    end
    next_cycle();
    idle_ports();
endtask

task automatic byte_read(input string what, input logic [`MEM_WORD_AW-1:0] word,
                         input logic [1:0] lane);
    byte_addr_u             ba;
    logic [`MEM_WORD_W-1:0] w;
    logic [7:0]             exp;
    logic                   served;
    served      = dbg_mode;
    ba.fld.word = word;
    ba.fld.lane = lane;
    byte_req    = '0;
    byte_req.en = 1'b1;
    byte_req.ai = ba;
    if (served && !model.exists(word)) begin
        abort_run("test sequence reads a byte of a word it never wrote");
    end
    w   = served ? model[word] : '0;
    exp = served ? w[lane*8 +: 8] : last_byte;  // lane 0 is the low byte
    next_cycle();
    idle_ports();
    if (served || byte_seen) begin
        check_byte(what, exp, byte_rd);
    end
    if (word_seen) begin
        check_word({what, ", word port held"}, last_word, word_rd);
    end
    if (served) begin
        last_byte = exp;
        byte_seen = 1'b1;
    end
endtask

task automatic test_masked_writes();
    logic [`MEM_WORD_AW-1:0] addr;
    addr     = 15'h0042;
    cur_test = "masked word writes";
    dbg_mode = 1'b0;
    word_write(addr, 4'hf, 32'h1122_3344);
    word_read("fill", addr);
    for (int m = 1; m < 16; m++) begin
        word_write(addr, m[3:0], xorshift32());
        word_read($sformatf("mask %h", m[3:0]), addr);
    end
endtask

task automatic test_bank_halves();
    cur_test = "bank halves";
    dbg_mode = 1'b0;
    word_write(15'h0123, 4'hf, 32'ha5a5_0123);
    word_write(15'h4123, 4'hf, 32'h5a5a_4123);
    word_read("low half", 15'h0123);
    word_read("high half", 15'h4123);
    for (int i = 0; i < 4; i++) begin
        word_read("alternating low", 15'h0123);  // back to back with the next read
        word_read("alternating high", 15'h4123);
    end
endtask

task automatic test_byte_port();
    logic [7:0] lane_val [4];
    lane_val = '{8'hde, 8'had, 8'hbe, 8'hef};
    cur_test = "byte port";
    dbg_mode = 1'b1;
    for (int l = 0; l < 4; l++) begin
        byte_write(15'h01a5, l[1:0], lane_val[l]);
    end
    for (int l = 0; l < 4; l++) begin
        byte_read($sformatf("lane %0d", l), 15'h01a5, l[1:0]);
    end
    dbg_mode = 1'b0;
    word_read("word view", 15'h01a5);
    check_word("little-endian order", 32'hefbe_adde, word_rd);
endtask

task automatic test_ownership();
    cur_test = "port ownership";
    dbg_mode = 1'b0;
    word_write(15'h0200, 4'hf, 32'h0bad_f00d);
    word_read("cpu owns memory", 15'h0200);
    dbg_mode = 1'b1;
    word_write(15'h0200, 4'hf, 32'hdead_beef);  // must be dropped
    word_read("dropped word read", 15'h0200);
    byte_read("lane 0 after dropped write", 15'h0200, 2'd0);
    byte_read("lane 3 after dropped write", 15'h0200, 2'd3);
    dbg_mode = 1'b0;
    byte_write(15'h0200, 2'd1, 8'h55);  // must be dropped
    byte_read("dropped byte read", 15'h0200, 2'd2);
    word_read("after dropped byte write", 15'h0200);
    check_word("memory unchanged", 32'h0bad_f00d, word_rd);
    check_byte("byte output held", 8'h0b, byte_rd);
endtask

task automatic test_random_mix();
    logic [`MEM_WORD_AW-1:0] pool [8];
    logic [`MEM_WORD_AW-1:0] addr;
    logic [31:0]             r;
    logic [3:0]              mask;
    cur_test = "random mix";
    dbg_mode = 1'b0;
    for (int i = 0; i < 8; i++) begin
        r = xorshift32();
        pool[i] = r[`MEM_WORD_AW-1:0];
        pool[i][`MEM_WORD_AW-1] = i[0];  // both bank pairs in use
        word_write(pool[i], 4'hf, xorshift32());
    end
    for (int n = 0; n < 300; n++) begin
        r        = xorshift32();
        dbg_mode = r[0];
        addr     = pool[r[5:3]];
        mask     = r[11:8];
        if (mask == 4'h0) begin
            mask = 4'hf;
        end
        case (r[2:1])
            2'd0:    word_write(addr, mask, xorshift32());
            2'd1:    word_read($sformatf("access %0d word read", n), addr);
            2'd2:    byte_write(addr, r[7:6], r[23:16]);
            default: byte_read($sformatf("access %0d byte read", n), addr, r[7:6]);
        endcase
    end
    dbg_mode = 1'b0;
endtask

`endif

//--- sim/forth_mem_tb.sv
// Testbench for the memory subsystem.
// Runs the directed tests from the included task file against forth_mem_top,
// then prints a single pass or fail line.
`timescale 1ns/100ps
`include "mem_params.svh"

module forth_mem_tb;

    import forth_mem_pkg::*;

    localparam int CLK_PERIOD = 8;

    // cycle budget per test, the watchdog limit is their sum
    localparam int CYC_RESET   = 4;
    localparam int CYC_MASKED  = 40;
    localparam int CYC_HALVES  = 20;
    localparam int CYC_BYTES   = 20;
    localparam int CYC_OWNER   = 30;
    localparam int CYC_RANDOM  = 330;
    localparam int CYC_MARGIN  = 100;
    localparam int WATCHDOG_NS = (CYC_RESET + CYC_MASKED + CYC_HALVES + CYC_BYTES
                                 + CYC_OWNER + CYC_RANDOM + CYC_MARGIN) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   dbg_mode;
    word_req_t              word_req;
    byte_req_t              byte_req;
    logic [`MEM_WORD_W-1:0] word_rd;
    logic [7:0]             byte_rd;

    // reference model of the whole memory, keyed by word address
    logic [`MEM_WORD_W-1:0] model [logic [`MEM_WORD_AW-1:0]];
    logic [`MEM_WORD_W-1:0] last_word;  // value word_rd must hold
    logic [7:0]             last_byte;  // value byte_rd must hold
    logic                   word_seen;  // a word read has been served
    logic                   byte_seen;
    logic [31:0]            rng_state;
    string                  cur_test;

    always #(CLK_PERIOD / 2) clk = ~clk;

    forth_mem_top forth_mem_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .dbg_mode (dbg_mode),
        .word_req (word_req),
        .byte_req (byte_req),
        .word_rd  (word_rd),
        .byte_rd  (byte_rd)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    `include "forth_mem_tasks.svh"

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout: the test sequence did not finish in time");
    end

    initial begin : main_seq
        rst_n     = 1'b0;
        dbg_mode  = 1'b0;
        word_req  = '0;
        byte_req  = '0;
        word_seen = 1'b0;
        byte_seen = 1'b0;
        last_word = '0;
        last_byte = '0;
        rng_state = 32'd53613;
        cur_test  = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_masked_writes();
        test_bank_halves();
        test_byte_port();
        test_ownership();
        test_random_mix();

        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
+incdir+sim
logic/forth_mem_pkg.sv
logic/spram_bank.sv
logic/word_mem.sv
logic/byte_port.sv
logic/mem_ctrl.sv
logic/forth_mem_top.sv
sim/forth_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it.
# The run counts as passed only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=forth_mem_sim
LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module forth_mem_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
